// ==== logic/wiscPkg.sv ====
`default_nettype none

package wiscPkg;

    localparam int dataWidth = 16;
    localparam int regAddrWidth = 3;
    localparam int memDepthDefault = 64;

    // instruction bits 15..11
    typedef enum logic [4:0] {
        opHalt = 5'b00000,
        opNop  = 5'b00001,
        opJ    = 5'b00100,
        opJr   = 5'b00101,
        opJal  = 5'b00110,
        opAddi = 5'b01000,
        opSubi = 5'b01001,
        opBeqz = 5'b01100,
        opBnez = 5'b01101,
        opSt   = 5'b10000,
        opLd   = 5'b10001,
        opSlbi = 5'b10010,
        opAdd  = 5'b10100,
        opSub  = 5'b10101,
        opAnd  = 5'b10110,
        opXor  = 5'b10111,
        opLbi  = 5'b11000,
        opBtr  = 5'b11001,
        opSeq  = 5'b11100,
        opSlt  = 5'b11101,
        opSle  = 5'b11110,
        opSco  = 5'b11111
    } opcodeT;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluXor,
        aluPass
    } aluOpT;

    // nine results need four bits
    typedef enum logic [3:0] {
        selAlu,
        selSlbi,
        selImm,
        selBtr,
        selSeq,
        selSlt,
        selSle,
        selSco,
        selLink
    } resultSelT;

    typedef struct packed {
        logic                    valid;
        logic [dataWidth-1:0]    pc;
        logic [dataWidth-1:0]    nextPc;
        logic [dataWidth-1:0]    rsVal;
        logic [dataWidth-1:0]    rtVal;
        logic [dataWidth-1:0]    imm;
        logic [regAddrWidth-1:0] dest;
        logic                    regWrite;
        logic                    memRead;
        logic                    memWrite;
        logic                    branch;
        logic                    jump;
        logic                    jumpReg;
        logic                    branchOnZero;
        aluOpT                   aluOp;
        resultSelT               resultSel;
        logic                    useImm;
        logic                    halt;
    } idExT;

    typedef struct packed {
        logic                    valid;
        logic [dataWidth-1:0]    result;
        logic [dataWidth-1:0]    storeData;
        logic [regAddrWidth-1:0] dest;
        logic                    regWrite;
        logic                    memRead;
        logic                    memWrite;
        logic                    halt;
    } exMemT;

    // valid here means a register write
    typedef struct packed {
        logic                    valid;
        logic                    halt;
        logic [regAddrWidth-1:0] dest;
        logic [dataWidth-1:0]    data;
    } wbT;

endpackage

`default_nettype wire

// ==== logic/regFile.sv ====
`timescale 1ns/1ns
`default_nettype none

module regFile (
    input  wire logic                                clk,
    input  wire logic                                rstN,
    input  wire logic [wiscPkg::regAddrWidth-1:0]    rdAddrA,
    input  wire logic [wiscPkg::regAddrWidth-1:0]    rdAddrB,
    input  wire wiscPkg::wbT                         wb,
    output logic      [wiscPkg::dataWidth-1:0]       rdDataA,
    output logic      [wiscPkg::dataWidth-1:0]       rdDataB
);

    import wiscPkg::*;

    localparam int numRegs = 2 ** regAddrWidth;

    logic [dataWidth-1:0] regs [numRegs];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid) begin
            regs[wb.dest] <= wb.data;
        end
    end

    // write-through so an issue in the write cycle sees the new value
    always_comb begin
        if (wb.valid && wb.dest == rdAddrA) begin
            rdDataA = wb.data;
        end else begin
            rdDataA = regs[rdAddrA];
        end
        if (wb.valid && wb.dest == rdAddrB) begin
            rdDataB = wb.data;
        end else begin
            rdDataB = regs[rdAddrB];
        end
    end

endmodule

`default_nettype wire

// ==== logic/decodeStage.sv ====
`timescale 1ns/1ns
`default_nettype none

module decodeStage (
    input  wire logic                                clk,
    input  wire logic                                rstN,
    input  wire logic                                instValid,
    input  wire logic [wiscPkg::dataWidth-1:0]       instr,
    input  wire logic [wiscPkg::dataWidth-1:0]       instPc,
    input  wire logic [wiscPkg::dataWidth-1:0]       rsData,
    input  wire logic [wiscPkg::dataWidth-1:0]       rtData,
    input  wire logic                                flush,
    output logic      [wiscPkg::regAddrWidth-1:0]    rsAddr,
    output logic      [wiscPkg::regAddrWidth-1:0]    rtAddr,
    output wiscPkg::idExT                            idEx,
    output logic                                     illegal
);

    import wiscPkg::*;

    opcodeT opcode;
    logic [regAddrWidth-1:0] rdIdx;
    logic [dataWidth-1:0] imm5s;
    logic [dataWidth-1:0] imm8s;
    logic [dataWidth-1:0] imm8z;
    logic [dataWidth-1:0] imm11s;
    logic legal;
    logic illegalQ;
    idExT next;

    assign opcode = opcodeT'(instr[15:11]);
    assign rsAddr = instr[10:8];
    assign rtAddr = instr[7:5];
    assign rdIdx = instr[4:2];

    // immediate formats
    assign imm5s = {{(dataWidth-5){instr[4]}}, instr[4:0]};
    assign imm8s = {{(dataWidth-8){instr[7]}}, instr[7:0]};
    assign imm8z = {{(dataWidth-8){1'b0}}, instr[7:0]};
    assign imm11s = {{(dataWidth-11){instr[10]}}, instr[10:0]};

    always_comb begin
        next = '0;
        next.valid = instValid;
        next.pc = instPc;
        next.nextPc = instPc + 1'b1;
        next.rsVal = rsData;
        next.rtVal = rtData;
        next.imm = imm5s;
        next.dest = rdIdx;
        next.aluOp = aluPass;
        next.resultSel = selAlu;
        legal = 1'b1;
        case (opcode)
            opAdd, opSub, opAnd, opXor: begin
                next.regWrite = 1'b1;
                next.aluOp = (opcode == opAdd) ? aluAdd :
                             (opcode == opSub) ? aluSub :
                             (opcode == opAnd) ? aluAnd : aluXor;
            end
            opAddi, opSubi, opLd: begin
                next.regWrite = 1'b1;
                next.dest = rtAddr;
                next.useImm = 1'b1;
                next.memRead = (opcode == opLd);
                next.aluOp = (opcode == opSubi) ? aluSub : aluAdd;
            end
            opSt: begin
                next.memWrite = 1'b1;
                next.useImm = 1'b1;
                next.aluOp = aluAdd;
            end
            opSlbi, opLbi: begin
                next.regWrite = 1'b1;
                next.dest = rsAddr;
                next.imm = (opcode == opSlbi) ? imm8z : imm8s;
                next.resultSel = (opcode == opSlbi) ? selSlbi : selImm;
            end
            opBtr: begin
                next.regWrite = 1'b1;
                next.resultSel = selBtr;
            end
            opSeq, opSlt, opSle, opSco: begin
                next.regWrite = 1'b1;
                next.aluOp = (opcode == opSco) ? aluAdd : aluSub;
                next.resultSel = (opcode == opSeq) ? selSeq :
                                 (opcode == opSlt) ? selSlt :
                                 (opcode == opSle) ? selSle : selSco;
            end
            opBeqz, opBnez: begin
                next.branch = 1'b1;
                next.branchOnZero = (opcode == opBeqz);
                next.imm = imm8s;
            end
            opJ, opJal: begin
                next.jump = 1'b1;
                next.imm = imm11s;
                next.regWrite = (opcode == opJal);
                next.dest = 3'd7;
                next.resultSel = selLink;
            end
            opJr: begin
                next.jump = 1'b1;
                next.jumpReg = 1'b1;
            end
            opHalt: next.halt = 1'b1;
            opNop: ;
            default: legal = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            idEx <= '0;
            illegalQ <= 1'b0;
        end else begin
            idEx <= next;
            illegalQ <= instValid && !legal;
        end
    end

    // an illegal word behind a taken branch is squashed, not reported
    assign illegal = illegalQ && !flush;

endmodule

`default_nettype wire

// ==== logic/executeStage.sv ====
`timescale 1ns/1ns
`default_nettype none

module executeStage (
    input  wire logic                             clk,
    input  wire logic                             rstN,
    input  wire wiscPkg::idExT                    idEx,
    output wiscPkg::exMemT                        exMem,
    output logic                                  redirect,
    output logic      [wiscPkg::dataWidth-1:0]    redirectPc
);

    import wiscPkg::*;

    logic live;
    logic [dataWidth-1:0] opA;
    logic [dataWidth-1:0] opB;
    logic [dataWidth:0] addSum;
    logic [dataWidth:0] subSum;
    logic [dataWidth-1:0] aluOut;
    logic zero;
    logic negative;
    logic carry;
    logic sltBit;
    logic [dataWidth-1:0] slbiOut;
    logic [dataWidth-1:0] btrOut;
    logic [dataWidth-1:0] result;
    logic condMet;
    logic taken;
    logic [dataWidth-1:0] target;
    exMemT next;

    // squash the slot behind a taken branch
    assign live = idEx.valid && !redirect;

    assign opA = idEx.rsVal;
    assign opB = idEx.useImm ? idEx.imm : idEx.rtVal;

    assign addSum = {1'b0, opA} + {1'b0, opB};
    assign subSum = {1'b0, opA} + {1'b0, ~opB} + 1'b1;

    always_comb begin
        case (idEx.aluOp)
            aluAdd:  aluOut = addSum[dataWidth-1:0];
            aluSub:  aluOut = subSum[dataWidth-1:0];
            aluAnd:  aluOut = opA & opB;
            aluXor:  aluOut = opA ^ opB;
            aluPass: aluOut = opB;
            default: aluOut = opB;
        endcase
    end

    assign zero = (aluOut == '0);
    assign negative = aluOut[dataWidth-1];
    assign carry = (idEx.aluOp == aluSub) ? subSum[dataWidth] : addSum[dataWidth];

    // differing signs decide without the difference
    always_comb begin
        if (opA[dataWidth-1] && !opB[dataWidth-1]) begin
            sltBit = 1'b1;
        end else if (!opA[dataWidth-1] && opB[dataWidth-1]) begin
            sltBit = 1'b0;
        end else begin
            sltBit = negative;
        end
    end

    assign slbiOut = (opA << 8) | idEx.imm;
    assign btrOut = {<<{opA}};

    always_comb begin
        case (idEx.resultSel)
            selAlu:  result = aluOut;
            selSlbi: result = slbiOut;
            selImm:  result = idEx.imm;
            selBtr:  result = btrOut;
            selSeq:  result = dataWidth'(zero);
            selSlt:  result = dataWidth'(sltBit);
            selSle:  result = dataWidth'(sltBit || zero);
            selSco:  result = dataWidth'(carry);
            selLink: result = idEx.nextPc;
            default: result = aluOut;
        endcase
    end

    // branch resolution
    assign condMet = idEx.branchOnZero ? (opA == '0) : (opA != '0);
    assign taken = live && (idEx.jump || (idEx.branch && condMet));
    assign target = (idEx.jumpReg ? opA : idEx.nextPc) + idEx.imm;

    always_comb begin
        next.valid = live;
        next.result = result;
        next.storeData = idEx.rtVal;
        next.dest = idEx.dest;
        next.regWrite = idEx.regWrite && live;
        next.memRead = idEx.memRead && live;
        next.memWrite = idEx.memWrite && live;
        next.halt = idEx.halt && live;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exMem <= '0;
            redirect <= 1'b0;
            redirectPc <= '0;
        end else begin
            exMem <= next;
            redirect <= taken;
            redirectPc <= target;
        end
    end

    // decode never sets both memory controls
    memCtrlExclusive: assert property (
        @(posedge clk) disable iff (!rstN)
        idEx.valid |-> !(idEx.memRead && idEx.memWrite)
    );

    resultKnown: assert property (
        @(posedge clk) disable iff (!rstN)
        exMem.valid |-> !$isunknown(exMem.result)
    );

    // the squash keeps a second redirect from following
    redirectSingle: assert property (
        @(posedge clk) disable iff (!rstN)
        redirect |=> !redirect
    );

endmodule

`default_nettype wire

// ==== logic/memoryStage.sv ====
`timescale 1ns/1ns
`default_nettype none

module memoryStage #(
    parameter int memDepth = wiscPkg::memDepthDefault
) (
    input  wire logic              clk,
    input  wire logic              rstN,
    input  wire wiscPkg::exMemT    exMem,
    output wiscPkg::wbT            wb
);

    import wiscPkg::*;

    localparam int addrWidth = $clog2(memDepth);

    logic [dataWidth-1:0] mem [memDepth];
    logic [addrWidth-1:0] addr;
    logic [dataWidth-1:0] loadData;
    logic doStore;

    assign addr = addrWidth'(exMem.result % memDepth);
    assign doStore = exMem.valid && exMem.memWrite;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < memDepth; i++) begin
                mem[i] <= '0;
            end
        end else if (doStore) begin
            mem[addr] <= exMem.storeData;
        end
    end

    // combinational read so load data lands with the write-back
    assign loadData = mem[addr];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wb <= '0;
        end else begin
            wb.valid <= exMem.valid && exMem.regWrite;
            wb.halt <= exMem.valid && exMem.halt;
            wb.dest <= exMem.dest;
            if (exMem.memRead) begin
                wb.data <= loadData;
            end else begin
                wb.data <= exMem.result;
            end
        end
    end

    addrInRange: assert property (
        @(posedge clk) disable iff (!rstN)
        (exMem.valid && (exMem.memRead || exMem.memWrite)) |-> (exMem.result < memDepth)
    );

endmodule

`default_nettype wire

// ==== logic/wiscCore.sv ====
`timescale 1ns/1ns
`default_nettype none

module wiscCore #(
    parameter int memDepth = wiscPkg::memDepthDefault
) (
    input  wire logic                                clk,
    input  wire logic                                rstN,
    input  wire logic                                instValid,
    input  wire logic [wiscPkg::dataWidth-1:0]       instr,
    input  wire logic [wiscPkg::dataWidth-1:0]       instPc,
    output logic                                     wbValid,
    output logic      [wiscPkg::regAddrWidth-1:0]    wbReg,
    output logic      [wiscPkg::dataWidth-1:0]       wbData,
    output logic                                     redirect,
    output logic      [wiscPkg::dataWidth-1:0]       redirectPc,
    output logic                                     halted,
    output logic                                     err
);

    import wiscPkg::*;

    logic [regAddrWidth-1:0] rsAddr;
    logic [regAddrWidth-1:0] rtAddr;
    logic [dataWidth-1:0] rsData;
    logic [dataWidth-1:0] rtData;
    logic illegal;
    idExT idEx;
    exMemT exMem;
    wbT wb;

    regFile i_regFile (.clk(clk), .rstN(rstN), .rdAddrA(rsAddr), .rdAddrB(rtAddr),
        .wb(wb), .rdDataA(rsData), .rdDataB(rtData));

    decodeStage i_decodeStage (.clk(clk), .rstN(rstN), .instValid(instValid),
        .instr(instr), .instPc(instPc), .rsData(rsData), .rtData(rtData),
        .flush(redirect), .rsAddr(rsAddr), .rtAddr(rtAddr), .idEx(idEx),
        .illegal(illegal));

    executeStage i_executeStage (.clk(clk), .rstN(rstN), .idEx(idEx), .exMem(exMem),
        .redirect(redirect), .redirectPc(redirectPc));

    memoryStage #(.memDepth(memDepth)) i_memoryStage (.clk(clk), .rstN(rstN),
        .exMem(exMem), .wb(wb));

    assign wbValid = wb.valid;
    assign wbReg = wb.dest;
    assign wbData = wb.data;

    // sticky status
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            halted <= 1'b0;
            err <= 1'b0;
        end else begin
            halted <= halted || wb.halt;
            err <= err || illegal;
        end
    end

endmodule

`default_nettype wire

// ==== sim/wiscCoreTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module wiscCoreTb;

    import wiscPkg::*;

    localparam int timeoutCycles = 50;

    logic clk;
    logic rstN;
    logic instValid;
    logic [dataWidth-1:0] instr;
    logic [dataWidth-1:0] instPc;
    logic wbValid;
    logic [regAddrWidth-1:0] wbReg;
    logic [dataWidth-1:0] wbData;
    logic redirect;
    logic [dataWidth-1:0] redirectPc;
    logic halted;
    logic err;

    wbT seenWb;
    wbT wbQueue[$];
    logic [dataWidth-1:0] redirectQueue[$];
    logic expHalt;
    logic expErr;
    logic sawHalt;
    int wbAge;
    int redirectAge;
    integer seed;

    wiscCore #(.memDepth(64)) i_wiscCore (.clk(clk), .rstN(rstN), .instValid(instValid),
        .instr(instr), .instPc(instPc), .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
        .redirect(redirect), .redirectPc(redirectPc), .halted(halted), .err(err));

    assign seenWb = {wbValid, 1'b0, wbReg, wbData};

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stopRun(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkWb(input wbT exp, input wbT got);
        if (got.dest !== exp.dest) begin
            stopRun($sformatf("error at %0t: wbReg expected %0d got %0d",
                $time, exp.dest, got.dest));
        end else if (got.data !== exp.data) begin
            stopRun($sformatf("error at %0t: wbData expected %h got %h",
                $time, exp.data, got.data));
        end
    endtask

    task automatic checkRedirect(input logic [dataWidth-1:0] exp,
                                 input logic [dataWidth-1:0] got);
        if (got !== exp) begin
            stopRun($sformatf("error at %0t: redirectPc expected %h got %h", $time, exp, got));
        end
    endtask

    task automatic checkHalt(input logic exp, input logic got);
        if (got !== exp) begin
            stopRun($sformatf("error at %0t: halted expected %b got %b", $time, exp, got));
        end
    endtask

    task automatic checkErr(input logic exp, input logic got);
        if (got !== exp) begin
            stopRun($sformatf("error at %0t: err expected %b got %b", $time, exp, got));
        end
    endtask

    function automatic string pendingEvent();
        if (wbQueue.size() != 0) begin
            return $sformatf("write-back to register %0d", wbQueue[0].dest);
        end else if (redirectQueue.size() != 0) begin
            return $sformatf("redirect to %h", redirectQueue[0]);
        end else if (halted !== expHalt) begin
            return "halted";
        end else if (err !== expErr) begin
            return "err";
        end
        return "";
    endfunction

    // outputs change on the rising edge, so look at them on the falling one
    always @(negedge clk) begin
        if (rstN) begin
            if (wbValid) begin
                if (wbQueue.size() == 0) begin
                    stopRun($sformatf("unexpected write-back to register %0d at %0t",
                        wbReg, $time));
                end else begin
                    checkWb(wbQueue.pop_front(), seenWb);
                end
                wbAge = 0;
            end else if (wbQueue.size() != 0) begin
                wbAge++;
            end
            if (redirect) begin
                if (redirectQueue.size() == 0) begin
                    stopRun($sformatf("unexpected redirect to %h at %0t", redirectPc, $time));
                end else begin
                    checkRedirect(redirectQueue.pop_front(), redirectPc);
                end
                redirectAge = 0;
            end else if (redirectQueue.size() != 0) begin
                redirectAge++;
            end
            if (wbAge > timeoutCycles) begin
                stopRun($sformatf("write-back to register %0d did not appear in time",
                    wbQueue[0].dest));
            end
            if (redirectAge > timeoutCycles) begin
                stopRun($sformatf("redirect to %h did not appear in time",
                    redirectQueue[0]));
            end
            if (halted && !expHalt) begin
                stopRun("halted went high although no halt was issued");
            end
            if (sawHalt && !halted) begin
                stopRun("halted dropped after it had been set");
            end
            if (err && !expErr) begin
                stopRun("err went high although no illegal instruction was issued");
            end
            sawHalt = sawHalt || halted;
        end
    end

    initial begin
        int fd;
        int extra;
        int waited;
        string line;
        byte kind;
        logic [dataWidth-1:0] a;
        logic [dataWidth-1:0] b;
        seed = 32'h9952;
        rstN = 1'b0;
        instValid = 1'b0;
        instr = '0;
        instPc = '0;
        expHalt = 1'b0;
        expErr = 1'b0;
        sawHalt = 1'b0;
        wbAge = 0;
        redirectAge = 0;
        fd = $fopen("sim/coreTrace.txt", "r");
        if (fd == 0) begin
            stopRun("could not open the trace file sim/coreTrace.txt");
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        while ($fgets(line, fd) != 0) begin
            a = '0;
            b = '0;
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            void'($sscanf(line, "%c %h %h", kind, a, b));
            case (kind)
                "I": begin
                    @(negedge clk);
                    instValid = 1'b1;
                    instr = a;
                    instPc = b;
                end
                "B": begin
                    extra = (b == 0) ? 0 : int'($unsigned($random(seed)) % (b + 1));
                    repeat (a + extra) begin
                        @(negedge clk);
                        instValid = 1'b0;
                        instr = '0;
                    end
                end
                "W": wbQueue.push_back({1'b1, 1'b0, a[regAddrWidth-1:0], b});
                "R": redirectQueue.push_back(a);
                "E": expErr = 1'b1;
                "H": expHalt = 1'b1;
                default: stopRun($sformatf("unknown trace record: %s", line));
            endcase
        end
        $fclose(fd);
        @(negedge clk);
        instValid = 1'b0;
        instr = '0;
        waited = 0;
        while (pendingEvent() != "" && waited < timeoutCycles) begin
            @(negedge clk);
            waited++;
        end
        if (pendingEvent() != "") begin
            stopRun({"timed out waiting for ", pendingEvent()});
        end
        // sticky flags still high a few cycles on
        repeat (4) @(negedge clk);
        checkHalt(expHalt, halted);
        checkErr(expErr, err);
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/coreTrace.txt ====
# I instr pc = issue, B count maxExtra = bubbles plus up to maxExtra random ones, all hex
# W reg data = write-back, R target = redirect, E = err expected, H = halt expected
I C17F 0000
W 1 007F
I C2FD 0001
W 2 FFFD
I C380 0002
W 3 FF80
B 2 3
I A150 0003
W 4 007C
I A954 0004
W 5 0082
I B278 0005
W 6 FF80
I B95C 0006
W 7 FF82
I 4199 0007
W 4 0078
I 4AA4 0008
W 5 FFF9
I CB18 0009
W 6 01FF
I E25C 000A
W 7 0001
I 91FF 000B
W 1 7FFF
B 2 0
I E970 000C
W 4 0000
I EB34 000D
W 5 0001
I F278 000E
W 6 0000
I F37C 000F
W 7 0001
I FA50 0010
W 4 0001
I 8045 0011
I 88C5 0012
W 6 FFFD
I 88E6 0013
W 7 0000
B 0 3
I 6203 0014
I 6803 0015
I 6004 0016
R 001B
I C555 0017
I 6AFE 001B
R 001A
I C555 001C
I 2005 001A
R 0020
I C555 001B
I 37F0 0020
R 0011
W 7 0021
I C555 0021
I 2901 0011
R 8000
I C555 0012
I 1000 8000
E
I 0000 8001
H

// ==== project.f ====
logic/wiscPkg.sv
logic/regFile.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/memoryStage.sv
logic/wiscCore.sv
sim/wiscCoreTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the wiscCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f project.f --top-module wiscCoreTb -Mdir obj_dir -o wiscCoreSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/wiscCoreSim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0
